//--- logic/replay_pkg.sv
/*
 * Shared definitions for the capture and replay engine
 * Sizes of the beat, the record memory and the output FIFO
 * Beat struct, beat/halves union and memory write struct
 */
package replay_pkg;

  // Stream beat payload
  localparam int data_width = 32;
  localparam int strb_width = 4;

  // Record memory, two words per beat
  localparam int half_width = 20;
  localparam int mem_depth = 64;
  localparam int mem_addr_width = 6;
  localparam int max_beats = mem_depth / 2;

  localparam int count_width = 8;

  // Output FIFO, also the starting credit count of the reader
  localparam int fifo_depth = 4;
  localparam int fifo_ptr_width = $clog2(fifo_depth);
  localparam int fifo_cnt_width = $clog2(fifo_depth + 1);

  typedef struct packed {
    logic [data_width-1:0] data;
    logic [strb_width-1:0] strb;
    logic                  last;
    logic [2:0]            pad;
  } beat_t;

  typedef struct packed {
    logic [half_width-1:0] hi;
    logic [half_width-1:0] lo;
  } halves_t;

  // Same 40 bits seen as a beat or as two memory words
  typedef union packed {
    beat_t   beat;
    halves_t halves;
  } beat_word_u;

  typedef struct packed {
    logic                      en;
    logic [mem_addr_width-1:0] addr;
    logic [half_width-1:0]     data;
  } mem_wr_t;

endpackage

//--- logic/capture_writer.sv
/*
 * Capture side of the replay engine
 * Accepts input stream beats, writes each as a low and a high memory word
 * on the two following cycles and keeps the recorded beat count
 */
`timescale 1ns/1ps

module capture_writer (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  s_tvalid,
  output logic                                  s_tready,
  input  replay_pkg::beat_t                     s_tdata,
  input  logic                                  replay_busy,
  output replay_pkg::mem_wr_t                   mem_wr,
  output logic [replay_pkg::mem_addr_width-1:0] rec_beats
);
  import replay_pkg::*;

  logic                      accept;
  logic                      full;
  logic                      store;
  logic                      lo_pend;
  logic                      hi_pend;
  logic [mem_addr_width-2:0] slot_q;
  beat_word_u                word_q;

  // One idle cycle after each accepted beat, none while replaying
  assign s_tready = !lo_pend && !replay_busy;
  assign accept = s_tvalid && s_tready;
  assign full = (rec_beats == mem_addr_width'(max_beats));

  // Beats arriving after the memory fills are taken and dropped
  assign store = accept && !full;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      lo_pend   <= 1'b0;
      hi_pend   <= 1'b0;
      rec_beats <= '0;
    end else begin
      lo_pend <= store;
      hi_pend <= lo_pend;
      if (store) begin
        rec_beats <= rec_beats + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (store) begin
      word_q.beat <= s_tdata;
      slot_q      <= rec_beats[mem_addr_width-2:0];
    end
  end

  // Low half goes to the even word, high half to the odd one
  always_comb begin
    mem_wr.en   = lo_pend || hi_pend;
    mem_wr.addr = {slot_q, hi_pend};
    mem_wr.data = hi_pend ? word_q.halves.hi : word_q.halves.lo;
  end

endmodule

//--- logic/record_memory.sv
/*
 * On-chip record memory
 * One synchronous write port, one registered read port
 */
`timescale 1ns/1ps

module record_memory (
  input  logic                                  clk,
  input  replay_pkg::mem_wr_t                   mem_wr,
  input  logic                                  rd_en,
  input  logic [replay_pkg::mem_addr_width-1:0] rd_addr,
  output logic [replay_pkg::half_width-1:0]     rd_data
);
  import replay_pkg::*;

  logic [half_width-1:0] mem [mem_depth];

  always_ff @(posedge clk) begin
    if (mem_wr.en) begin
      mem[mem_wr.addr] <= mem_wr.data;
    end
  end

  // Read data follows rd_en by one cycle and holds otherwise
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

//--- logic/replay_reader.sv
/*
 * Replay side of the engine
 * FSM reading the recorded region once per pass, rebuilding each beat
 * from its two memory words and pushing it to the output FIFO
 * Credit counter for the free FIFO slots
 */
`timescale 1ns/1ps

module replay_reader (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  start_replay,
  input  logic [replay_pkg::count_width-1:0]    replay_count,
  input  logic [replay_pkg::mem_addr_width-1:0] rec_beats,
  output logic                                  rd_en,
  output logic [replay_pkg::mem_addr_width-1:0] rd_addr,
  input  logic [replay_pkg::half_width-1:0]     rd_data,
  output logic                                  push,
  output replay_pkg::beat_t                     push_beat,
  input  logic                                  credit_return,
  output logic                                  replay_busy
);
  import replay_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_rd_lo,
    st_rd_hi,
    st_push
  } state_t;

  state_t                    state;
  logic                      start_ok;
  logic                      last_beat;
  logic [mem_addr_width-1:0] rec_last;
  logic [mem_addr_width-2:0] beat_idx;
  logic [mem_addr_width-2:0] last_idx;
  logic [count_width-1:0]    passes_left;
  logic [fifo_cnt_width-1:0] credits;
  logic [half_width-1:0]     lo_q;
  beat_word_u                word;

  // Ignored while busy, with a zero count or with nothing recorded
  assign start_ok = start_replay && (state == st_idle) &&
                    (replay_count != '0) && (rec_beats != '0);

  assign rec_last = rec_beats - 1'b1;
  assign last_beat = (beat_idx == last_idx);

  assign rd_en = (state == st_rd_lo) || (state == st_rd_hi);
  assign rd_addr = {beat_idx, state == st_rd_hi};

  assign push = (state == st_push) && (credits != '0);
  assign replay_busy = (state != st_idle);

  // Low word was latched earlier, high word still sits on rd_data
  always_comb begin
    word.halves.lo = lo_q;
    word.halves.hi = rd_data;
  end

  assign push_beat = word.beat;

  always_ff @(posedge clk) begin
    if (state == st_rd_hi) begin
      lo_q <= rd_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state       <= st_idle;
      beat_idx    <= '0;
      last_idx    <= '0;
      passes_left <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (start_ok) begin
            state       <= st_rd_lo;
            beat_idx    <= '0;
            last_idx    <= rec_last[mem_addr_width-2:0];
            passes_left <= replay_count;
          end
        end
        st_rd_lo: state <= st_rd_hi;
        st_rd_hi: state <= st_push;
        st_push: begin
          // Wait here until a FIFO slot is free
          if (push) begin
            if (last_beat) begin
              beat_idx <= '0;
              if (passes_left == count_width'(1)) begin
                state <= st_idle;
              end else begin
                passes_left <= passes_left - 1'b1;
                state       <= st_rd_lo;
              end
            end else begin
              beat_idx <= beat_idx + 1'b1;
              state    <= st_rd_lo;
            end
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // One credit spent per push, one returned per pop
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      credits <= fifo_cnt_width'(fifo_depth);
    end else begin
      case ({push, credit_return})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
    end
  end

endmodule

//--- logic/stream_out_buffer.sv
/*
 * Output beat FIFO
 * Circular buffer driving the output stream from its head entry
 * and returning one credit per beat popped
 */
`timescale 1ns/1ps

module stream_out_buffer (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              push,
  input  replay_pkg::beat_t push_beat,
  output logic              credit_return,
  output logic              m_tvalid,
  input  logic              m_tready,
  output replay_pkg::beat_t m_tdata
);
  import replay_pkg::*;

  beat_t                     fifo_mem [fifo_depth];
  logic [fifo_ptr_width-1:0] wr_ptr;
  logic [fifo_ptr_width-1:0] rd_ptr;
  logic [fifo_cnt_width-1:0] count;
  logic                      pop;

  function automatic logic [fifo_ptr_width-1:0] next_ptr(
    input logic [fifo_ptr_width-1:0] ptr
  );
    if (ptr == fifo_ptr_width'(fifo_depth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // Head entry is not written again until it has been popped
  assign m_tvalid = (count != '0);
  assign m_tdata = fifo_mem[rd_ptr];
  assign pop = m_tvalid && m_tready;
  assign credit_return = pop;

  // No full check, the reader never pushes without a credit
  always_ff @(posedge clk) begin
    if (push) begin
      fifo_mem[wr_ptr] <= push_beat;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

//--- logic/pcap_replay_top.sv
/*
 * Packet capture and replay engine, top level
 * Connects the capture writer, record memory, replay reader
 * and output FIFO on the single stream clock
 */
`timescale 1ns/1ps

module pcap_replay_top (
  input  logic                               axi_aclk,
  input  logic                               rst_n,
  input  logic                               s_tvalid,
  output logic                               s_tready,
  input  replay_pkg::beat_t                  s_tdata,
  output logic                               m_tvalid,
  input  logic                               m_tready,
  output replay_pkg::beat_t                  m_tdata,
  input  logic                               start_replay,
  input  logic [replay_pkg::count_width-1:0] replay_count,
  output logic                               replay_busy
);
  import replay_pkg::*;

  mem_wr_t                   mem_wr;
  logic [mem_addr_width-1:0] rec_beats;
  logic                      rd_en;
  logic [mem_addr_width-1:0] rd_addr;
  logic [half_width-1:0]     rd_data;
  logic                      push;
  beat_t                     push_beat;
  logic                      credit_return;

  capture_writer capture_writer_inst (
    .clk         (axi_aclk),
    .rst_n       (rst_n),
    .s_tvalid    (s_tvalid),
    .s_tready    (s_tready),
    .s_tdata     (s_tdata),
    .replay_busy (replay_busy),
    .mem_wr      (mem_wr),
    .rec_beats   (rec_beats)
  );

  record_memory record_memory_inst (
    .clk     (axi_aclk),
    .mem_wr  (mem_wr),
    .rd_en   (rd_en),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  replay_reader replay_reader_inst (
    .clk           (axi_aclk),
    .rst_n         (rst_n),
    .start_replay  (start_replay),
    .replay_count  (replay_count),
    .rec_beats     (rec_beats),
    .rd_en         (rd_en),
    .rd_addr       (rd_addr),
    .rd_data       (rd_data),
    .push          (push),
    .push_beat     (push_beat),
    .credit_return (credit_return),
    .replay_busy   (replay_busy)
  );

  stream_out_buffer stream_out_buffer_inst (
    .clk           (axi_aclk),
    .rst_n         (rst_n),
    .push          (push),
    .push_beat     (push_beat),
    .credit_return (credit_return),
    .m_tvalid      (m_tvalid),
    .m_tready      (m_tready),
    .m_tdata       (m_tdata)
  );

endmodule

//--- verification/tb_pcap_replay.sv
/*
 * Testbench for the packet capture and replay engine
 * Reads capture beats, replay commands and expected beats from the vector file,
 * rebuilds the expected replay output, drives both streams and checks the output
 */
`timescale 1ns/1ps

module tb_pcap_replay;
  import replay_pkg::*;

  localparam int num_records = 32;
  localparam int clk_period = 20;

  logic                   clk;
  logic                   rst_n;
  logic                   s_tvalid;
  logic                   s_tready;
  beat_t                  s_tdata;
  logic                   m_tvalid;
  logic                   m_tready;
  beat_t                  m_tdata;
  logic                   start_replay;
  logic [count_width-1:0] replay_count;
  logic                   replay_busy;

  // Record fields are kind, flags, count or position and a 40-bit beat
  logic [55:0] vectors [num_records];
  logic [55:0] exp_recs [$];
  beat_t       cap_list [$];
  beat_t       got [$];
  logic        bp_mode;
  logic        ready_next;
  logic        stalled;
  beat_t       held;
  int          cycles;
  int          cycle_limit;

  pcap_replay_top uut (
    .axi_aclk     (clk),
    .rst_n        (rst_n),
    .s_tvalid     (s_tvalid),
    .s_tready     (s_tready),
    .s_tdata      (s_tdata),
    .m_tvalid     (m_tvalid),
    .m_tready     (m_tready),
    .m_tdata      (m_tdata),
    .start_replay (start_replay),
    .replay_count (replay_count),
    .replay_busy  (replay_busy)
  );

  always #(clk_period / 2) clk = ~clk;

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    assert (actual === expected) else begin
      $display("ERROR %s: expected %h, actual %h", name, expected, actual);
      $display("SIMULATION FAILED");
      $fatal(1, "value check failed");
    end
  endtask

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycle_limit > 0 && cycles > cycle_limit) begin
      $display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
      $display("SIMULATION FAILED");
      $fatal(1, "run stopped by the cycle limit");
    end
  end

  // Sink readiness with random gaps during back-pressure tests
  initial begin
    void'($urandom(32'h1cfb_6588));
    forever begin
      @(posedge clk);
      ready_next = bp_mode ? (($urandom % 3) != 0) : 1'b1;
      #2;
      m_tready = ready_next;
    end
  end

  // Output monitor
  always @(posedge clk) begin
    if (rst_n) begin
      if (stalled) begin
        check_value("output held under back-pressure", {1'b1, held}, {m_tvalid, m_tdata});
      end
      if (m_tvalid && m_tready) begin
        got.push_back(m_tdata);
      end
      stalled = m_tvalid && !m_tready;
      held = m_tdata;
    end
  end

  // Data field steps by one for each copy
  task automatic capture_beats(input beat_t first, input int copies);
    beat_t b;
    for (int i = 0; i < copies; i++) begin
      b = first;
      b.data = first.data + i;
      s_tdata = b;
      s_tvalid = 1'b1;
      @(posedge clk);
      while (!s_tready) begin
        @(posedge clk);
      end
      cap_list.push_back(b);
      #2;
    end
    s_tvalid = 1'b0;
  endtask

  task automatic run_replay(input int cmd_num, input logic [3:0] flags,
                            input logic [count_width-1:0] count, input int file_count);
    beat_t rebuilt [$];
    int    stored;
    int    idx;
    logic  valid;
    string name;
    // Memory keeps the first 32 beats and each pass replays all of them
    stored = (cap_list.size() < max_beats) ? cap_list.size() : max_beats;
    valid = (count != '0) && (stored != 0);
    if (valid) begin
      for (int p = 0; p < count; p++) begin
        for (int i = 0; i < stored; i++) begin
          rebuilt.push_back(cap_list[i]);
        end
      end
    end
    name = $sformatf("replay %0d", cmd_num);
    check_value({name, " beat count from file"}, file_count, rebuilt.size());
    foreach (exp_recs[k]) begin
      idx = exp_recs[k][47:40];
      check_value({name, " beat from file"}, exp_recs[k][39:0], rebuilt[idx]);
    end
    exp_recs.delete();
    bp_mode = flags[0];
    got.delete();
    replay_count = count;
    start_replay = 1'b1;
    @(posedge clk);
    #2;
    start_replay = 1'b0;
    check_value({name, " busy after start"}, valid, replay_busy);
    if (flags[1]) begin
      repeat (3) @(posedge clk);
      #2;
      check_value({name, " busy before second start"}, 1, replay_busy);
      replay_count = 8'd2;
      start_replay = 1'b1;
      @(posedge clk);
      #2;
      start_replay = 1'b0;
    end
    while (got.size() < rebuilt.size()) begin
      @(posedge clk);
      #2;
    end
    // Idle stretch catches extra beats
    repeat (20) @(posedge clk);
    #2;
    check_value({name, " output beat count"}, rebuilt.size(), got.size());
    check_value({name, " busy after last beat"}, 0, replay_busy);
    foreach (rebuilt[i]) begin
      check_value($sformatf("%s beat %0d", name, i), rebuilt[i], got[i]);
    end
    bp_mode = 1'b0;
  endtask

  initial begin
    logic [55:0] rec;
    int          total;
    int          cmd_num;
    clk = 1'b0;
    rst_n = 1'b0;
    s_tvalid = 1'b0;
    s_tdata = '0;
    m_tready = 1'b1;
    start_replay = 1'b0;
    replay_count = '0;
    bp_mode = 1'b0;
    stalled = 1'b0;
    held = '0;
    cycles = 0;
    cycle_limit = 0;
    $readmemh("verification/replay_vectors.mem", vectors);
    total = 0;
    for (int r = 0; r < num_records && vectors[r][55:52] != 4'h0; r++) begin
      if (vectors[r][55:52] == 4'h3) begin
        total += vectors[r][15:0];
      end
    end
    cycle_limit = 20 * total + 200;
    repeat (10) @(posedge clk);
    #2;
    rst_n = 1'b1;
    @(posedge clk);
    #2;
    check_value("idle outputs after reset", 3'b100, {s_tready, m_tvalid, replay_busy});
    cmd_num = 0;
    for (int r = 0; r < num_records; r++) begin
      rec = vectors[r];
      if (rec[55:52] == 4'h0) begin
        break;
      end
      case (rec[55:52])
        4'h1: capture_beats(rec[39:0], rec[47:40]);
        4'h2: exp_recs.push_back(rec);
        4'h3: begin
          cmd_num++;
          run_replay(cmd_num, rec[51:48], rec[47:40], rec[15:0]);
        end
        default: begin
          $display("Vector record %0d has an unknown kind", r);
          $display("SIMULATION FAILED");
          $fatal(1, "bad vector file");
        end
      endcase
    end
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

//--- verification/replay_vectors.mem
// kind | flags | count or position | beat data | strb, last, pad
// kind 1 capture (count = copies, data steps by one), 2 expected beat at a position,
// kind 3 replay (flags: 1 back-pressure, 2 second start; low four digits: expected beats)
// Five beats, mixed strobes and last flags
1001a5a5000130
1001deadbeeff8
10010000000118
1001cafef00d71
10011234567889
// Single pass, every field given
2000a5a5000130
2001deadbeeff8
20020000000118
2003cafef00d71
20041234567889
30010000000005
// Three passes
3003000000000f
// Two passes under random back-pressure
3102000000000a
// Zero count, then a second start during a busy pass
30000000000000
32010000000005
// Thirty more beats, memory fills at 32
101e00000100f0
200500000100f0
201f0000011af0
31010000000020
00000000000000

//--- build.f
logic/replay_pkg.sv
logic/capture_writer.sv
logic/record_memory.sv
logic/replay_reader.sv
logic/stream_out_buffer.sv
logic/pcap_replay_top.sv
verification/tb_pcap_replay.sv
